//--- rtl/dmem_pkg.sv
package dmem_pkg;

	// Word and lane sizes
	localparam int DATA_W = 32;
	localparam int BE_W = 4;

	// RAM holds 1024 words, the core sees one more address bit for I/O
	localparam int MEM_AW = 10;
	localparam int MEM_WORDS = 1 << MEM_AW;
	localparam int CORE_AW = 11;

	// I/O window just above the RAM
	localparam logic [CORE_AW-1:0] ADDR_BTN = 11'h400;
	localparam logic [CORE_AW-1:0] ADDR_SW = 11'h401;
	localparam logic [CORE_AW-1:0] ADDR_LED = 11'h402;

	// Board I/O widths
	localparam int BTN_W = 4;
	localparam int SW_W = 4;
	localparam int LED_W = 4;

	// Core load/store request
	// All-zero byte enables means a read
	typedef struct packed {
		logic [BE_W-1:0] be;
		logic [CORE_AW-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} core_req_t;

	// RAM-bound request, same fields with the narrower address
	typedef struct packed {
		logic [BE_W-1:0] be;
		logic [MEM_AW-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} mem_req_t;

	// Response, data only meaningful for reads
	typedef struct packed {
		logic [DATA_W-1:0] rdata;
	} rsp_t;

endpackage

//--- rtl/dmem_ram.sv
`timescale 1ns/1ps

module dmem_ram
	import dmem_pkg::*;
(
	input logic clk,
	input logic en,
	input logic [BE_W-1:0] we,
	input logic [MEM_AW-1:0] addr,
	input logic [DATA_W-1:0] wdata,
	output logic [DATA_W-1:0] rdata
);

	// Word-wide storage, written one byte lane at a time
	logic [DATA_W-1:0] mem [0:MEM_WORDS-1];

	// Byte-lane writes
	always_ff @(posedge clk) begin
		if (en) begin
			for (int i = 0; i < BE_W; i++) begin
				// Only the enabled lanes change
				if (we[i]) begin
					mem[addr][8*i +: 8] <= wdata[8*i +: 8];
				end
			end
		end
	end

	// Registered read
	// Old word comes out on a write to the same address
	always_ff @(posedge clk) begin
		if (en) begin
			rdata <= mem[addr];
		end
	end

endmodule

//--- rtl/dmem_req_buffer.sv
`timescale 1ns/1ps

module dmem_req_buffer
	import dmem_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic req_valid,
	input mem_req_t req,
	input logic grant,
	input logic rsp_valid,
	output logic pending,
	output mem_req_t held
);

	// Set from capture until the response strobe
	logic in_flight;

	// Pending flag, up from capture until the grant cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= 1'b0;
		end else if (req_valid) begin
			pending <= 1'b1;
		end else if (grant) begin
			pending <= 1'b0;
		end
	end

	// Outstanding tracking
	// A new strobe in the response cycle keeps the flag up
	always_ff @(posedge clk) begin
		if (rst) begin
			in_flight <= 1'b0;
		end else begin
			if (rsp_valid) begin
				in_flight <= 1'b0;
			end
			if (req_valid) begin
				in_flight <= 1'b1;
			end
		end
	end

	// Request payload
	always_ff @(posedge clk) begin
		if (req_valid) begin
			held <= req;
		end
	end

	// No back-pressure, so a second strobe before the response is lost
	a_one_outstanding: assert property (
		@(posedge clk) disable iff (rst)
		req_valid |-> !pending && (!in_flight || rsp_valid)
	) else $error("request strobe while previous request outstanding");

endmodule

//--- rtl/dmem_arbiter.sv
`timescale 1ns/1ps

module dmem_arbiter
	import dmem_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic core_pending,
	input logic con_pending,
	input mem_req_t core_held,
	input mem_req_t con_held,
	input logic [DATA_W-1:0] ram_rdata,
	output logic core_grant,
	output logic con_grant,
	output logic ram_en,
	output logic [BE_W-1:0] ram_we,
	output logic [MEM_AW-1:0] ram_addr,
	output logic [DATA_W-1:0] ram_wdata,
	output logic core_mem_rsp_valid,
	output logic con_mem_rsp_valid,
	output rsp_t mem_rsp
);

	// Controller wins the next conflict when set
	logic con_first;
	// Both buffers asking in the same cycle
	logic conflict;
	// Request steered onto the RAM
	mem_req_t sel;

	assign conflict = core_pending && con_pending;

	// Single requester always wins, otherwise the priority flag decides
	assign core_grant = core_pending && (!con_pending || !con_first);
	assign con_grant = con_pending && (!core_pending || con_first);

	// Loser of a conflict goes first next time
	always_ff @(posedge clk) begin
		if (rst) begin
			con_first <= 1'b0;
		end else if (conflict) begin
			con_first <= core_grant;
		end
	end

	// RAM drive from the granted buffer
	assign sel = con_grant ? con_held : core_held;
	assign ram_en = core_grant || con_grant;
	assign ram_we = sel.be;
	assign ram_addr = sel.addr;
	assign ram_wdata = sel.wdata;

	// Winner remembered for the cycle the RAM data appears
	always_ff @(posedge clk) begin
		if (rst) begin
			core_mem_rsp_valid <= 1'b0;
			con_mem_rsp_valid <= 1'b0;
		end else begin
			core_mem_rsp_valid <= core_grant;
			con_mem_rsp_valid <= con_grant;
		end
	end

	// RAM output is already registered, pass straight through
	assign mem_rsp.rdata = ram_rdata;

	a_grant_onehot: assert property (
		@(posedge clk) disable iff (rst)
		!(core_grant && con_grant)
	) else $error("both requesters granted");

	// Losing one conflict at most, so service within two cycles
	a_core_served: assert property (
		@(posedge clk) disable iff (rst)
		core_pending |-> ##[0:1] core_grant
	) else $error("core request starved");

	a_con_served: assert property (
		@(posedge clk) disable iff (rst)
		con_pending |-> ##[0:1] con_grant
	) else $error("controller request starved");

endmodule

//--- rtl/core_io_port.sv
`timescale 1ns/1ps

module core_io_port
	import dmem_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic core_req_valid,
	input core_req_t core_req,
	input logic [BTN_W-1:0] btn,
	input logic [SW_W-1:0] sw,
	input logic mem_rsp_valid,
	input rsp_t mem_rsp,
	output logic mem_req_valid,
	output mem_req_t mem_req,
	output logic core_rsp_valid,
	output rsp_t core_rsp,
	output logic [LED_W-1:0] led
);

	// Address below the I/O window
	logic is_ram;
	// Two-stage synchronisers for the board inputs
	logic [BTN_W-1:0] btn_s1;
	logic [BTN_W-1:0] btn_s2;
	logic [SW_W-1:0] sw_s1;
	logic [SW_W-1:0] sw_s2;
	// Full LED word, only the low bits reach the pins
	logic [DATA_W-1:0] led_reg;
	// Local I/O response
	logic mmio_rsp_valid;
	rsp_t mmio_rsp;

	assign is_ram = core_req.addr < ADDR_BTN;

	// RAM traffic goes on to the request buffer
	assign mem_req_valid = core_req_valid && is_ram;
	assign mem_req.be = core_req.be;
	assign mem_req.addr = core_req.addr[MEM_AW-1:0];
	assign mem_req.wdata = core_req.wdata;

	// Async inputs
	always_ff @(posedge clk) begin
		if (rst) begin
			btn_s1 <= '0;
			btn_s2 <= '0;
			sw_s1 <= '0;
			sw_s2 <= '0;
		end else begin
			btn_s1 <= btn;
			btn_s2 <= btn_s1;
			sw_s1 <= sw;
			sw_s2 <= sw_s1;
		end
	end

	// LED register with byte-lane merge
	// Any enable pattern works, not just aligned halfwords
	always_ff @(posedge clk) begin
		if (rst) begin
			led_reg <= '0;
		end else if (core_req_valid && core_req.addr == ADDR_LED) begin
			for (int i = 0; i < BE_W; i++) begin
				if (core_req.be[i]) begin
					led_reg[8*i +: 8] <= core_req.wdata[8*i +: 8];
				end
			end
		end
	end

	assign led = led_reg[LED_W-1:0];

	// I/O response strobe, one cycle after the request
	always_ff @(posedge clk) begin
		if (rst) begin
			mmio_rsp_valid <= 1'b0;
		end else begin
			mmio_rsp_valid <= core_req_valid && !is_ram;
		end
	end

	// I/O read data
	// Unmapped window addresses read zero
	always_ff @(posedge clk) begin
		case (core_req.addr)
			ADDR_BTN: mmio_rsp.rdata <= {{(DATA_W-BTN_W){1'b0}}, btn_s2};
			ADDR_SW: mmio_rsp.rdata <= {{(DATA_W-SW_W){1'b0}}, sw_s2};
			ADDR_LED: mmio_rsp.rdata <= led_reg;
			default: mmio_rsp.rdata <= '0;
		endcase
	end

	// Merge of the two response sources
	assign core_rsp_valid = mmio_rsp_valid || mem_rsp_valid;
	assign core_rsp = mmio_rsp_valid ? mmio_rsp : mem_rsp;

	// One core request outstanding, so the two paths never answer together
	a_rsp_exclusive: assert property (
		@(posedge clk) disable iff (rst)
		!(mmio_rsp_valid && mem_rsp_valid)
	) else $error("I/O and RAM responses collided");

endmodule

//--- rtl/datamem_top.sv
`timescale 1ns/1ps

module datamem_top
	import dmem_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic core_req_valid,
	input core_req_t core_req,
	input logic con_req_valid,
	input mem_req_t con_req,
	input logic [BTN_W-1:0] btn,
	input logic [SW_W-1:0] sw,
	output logic core_rsp_valid,
	output rsp_t core_rsp,
	output logic con_rsp_valid,
	output rsp_t con_rsp,
	output logic [LED_W-1:0] led
);

	// Core RAM request into its buffer
	logic core_mem_req_valid;
	mem_req_t core_mem_req;
	// Buffer to arbiter
	logic core_pending;
	logic con_pending;
	mem_req_t core_held;
	mem_req_t con_held;
	logic core_grant;
	logic con_grant;
	// Arbiter to RAM
	logic ram_en;
	logic [BE_W-1:0] ram_we;
	logic [MEM_AW-1:0] ram_addr;
	logic [DATA_W-1:0] ram_wdata;
	logic [DATA_W-1:0] ram_rdata;
	// RAM responses
	logic core_mem_rsp_valid;
	logic con_mem_rsp_valid;
	rsp_t mem_rsp;

	core_io_port i_core_port (
		.clk(clk),
		.rst(rst),
		.core_req_valid(core_req_valid),
		.core_req(core_req),
		.btn(btn),
		.sw(sw),
		.mem_rsp_valid(core_mem_rsp_valid),
		.mem_rsp(mem_rsp),
		.mem_req_valid(core_mem_req_valid),
		.mem_req(core_mem_req),
		.core_rsp_valid(core_rsp_valid),
		.core_rsp(core_rsp),
		.led(led)
	);

	dmem_req_buffer i_core_buf (
		.clk(clk),
		.rst(rst),
		.req_valid(core_mem_req_valid),
		.req(core_mem_req),
		.grant(core_grant),
		.rsp_valid(core_mem_rsp_valid),
		.pending(core_pending),
		.held(core_held)
	);

	// Controller goes straight into its buffer
	dmem_req_buffer i_con_buf (
		.clk(clk),
		.rst(rst),
		.req_valid(con_req_valid),
		.req(con_req),
		.grant(con_grant),
		.rsp_valid(con_mem_rsp_valid),
		.pending(con_pending),
		.held(con_held)
	);

	dmem_arbiter i_arbiter (
		.clk(clk),
		.rst(rst),
		.core_pending(core_pending),
		.con_pending(con_pending),
		.core_held(core_held),
		.con_held(con_held),
		.ram_rdata(ram_rdata),
		.core_grant(core_grant),
		.con_grant(con_grant),
		.ram_en(ram_en),
		.ram_we(ram_we),
		.ram_addr(ram_addr),
		.ram_wdata(ram_wdata),
		.core_mem_rsp_valid(core_mem_rsp_valid),
		.con_mem_rsp_valid(con_mem_rsp_valid),
		.mem_rsp(mem_rsp)
	);

	dmem_ram i_ram (
		.clk(clk),
		.en(ram_en),
		.we(ram_we),
		.addr(ram_addr),
		.wdata(ram_wdata),
		.rdata(ram_rdata)
	);

	// Controller sees only RAM responses
	assign con_rsp_valid = con_mem_rsp_valid;
	assign con_rsp = mem_rsp;

endmodule

//--- testbench/tb_datamem.sv
`timescale 1ns/1ps

module tb_datamem
	import dmem_pkg::*;
();

	// Worst case about 7 cycles per request, roughly 420 requests per peer
	localparam int TIMEOUT_CYCLES = 6000;
	// Private regions of the two peers, plus one shared word
	localparam logic [MEM_AW-1:0] CON_BASE = 10'h200;
	localparam logic [MEM_AW-1:0] SHARED_WORD = 10'h100;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic core_req_valid = 1'b0;
	core_req_t core_req = '0;
	logic con_req_valid = 1'b0;
	mem_req_t con_req = '0;
	logic [BTN_W-1:0] btn = '0;
	logic [SW_W-1:0] sw = '0;
	logic core_rsp_valid;
	rsp_t core_rsp;
	logic con_rsp_valid;
	rsp_t con_rsp;
	logic [LED_W-1:0] led;

	// Reference model
	logic [DATA_W-1:0] mem_model [0:MEM_WORDS-1];
	logic [DATA_W-1:0] led_model = '0;
	// Per-peer request in flight
	logic core_busy = 1'b0;
	logic core_mmio;
	logic core_rd;
	logic [DATA_W-1:0] core_exp;
	int core_t0;
	logic con_busy = 1'b0;
	logic con_rd;
	logic [DATA_W-1:0] con_exp;
	int con_t0;
	int cycle = 0;
	logic rst_d = 1'b1;

	datamem_top i_dut (
		.clk(clk),
		.rst(rst),
		.core_req_valid(core_req_valid),
		.core_req(core_req),
		.con_req_valid(con_req_valid),
		.con_req(con_req),
		.btn(btn),
		.sw(sw),
		.core_rsp_valid(core_rsp_valid),
		.core_rsp(core_rsp),
		.con_rsp_valid(con_rsp_valid),
		.con_rsp(con_rsp),
		.led(led)
	);

	always #10 clk = ~clk;

	task automatic end_in_failure();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string what);
		$display("MISMATCH at %0t: %s", $time, what);
		end_in_failure();
	endtask

	// Only the enabled byte lanes take the new data
	function automatic logic [DATA_W-1:0] merge_lanes(input logic [DATA_W-1:0] old,
			input logic [DATA_W-1:0] wdata, input logic [BE_W-1:0] be);
		logic [DATA_W-1:0] res;
		res = old;
		for (int i = 0; i < BE_W; i++) begin
			if (be[i]) begin
				res[8*i +: 8] = wdata[8*i +: 8];
			end
		end
		return res;
	endfunction

	// What a core read of this address should return
	function automatic logic [DATA_W-1:0] core_expect(input logic [CORE_AW-1:0] addr);
		if (addr < ADDR_BTN) begin
			return mem_model[addr[MEM_AW-1:0]];
		end else if (addr == ADDR_BTN) begin
			return {{(DATA_W-BTN_W){1'b0}}, btn};
		end else if (addr == ADDR_SW) begin
			return {{(DATA_W-SW_W){1'b0}}, sw};
		end else if (addr == ADDR_LED) begin
			return led_model;
		end
		// Unmapped part of the window
		return '0;
	endfunction

	// Strobe one core request, wait for its answer, then idle a little
	task automatic core_access(input logic [BE_W-1:0] be, input logic [CORE_AW-1:0] addr,
			input logic [DATA_W-1:0] data);
		core_req_valid <= 1'b1;
		core_req <= {be, addr, data};
		@(posedge clk);
		core_req_valid <= 1'b0;
		@(posedge clk);
		while (!core_rsp_valid) begin
			@(posedge clk);
		end
		repeat ($urandom_range(3)) @(posedge clk);
	endtask

	task automatic con_access(input logic [BE_W-1:0] be, input logic [MEM_AW-1:0] addr,
			input logic [DATA_W-1:0] data);
		con_req_valid <= 1'b1;
		con_req <= {be, addr, data};
		@(posedge clk);
		con_req_valid <= 1'b0;
		@(posedge clk);
		while (!con_rsp_valid) begin
			@(posedge clk);
		end
		repeat ($urandom_range(3)) @(posedge clk);
	endtask

	// New board inputs, held 3 cycles for the synchroniser, then read back
	task automatic board_read(input logic [CORE_AW-1:0] addr);
		btn <= $urandom_range(15);
		sw <= $urandom_range(15);
		repeat (3) @(posedge clk);
		core_access(4'h0, addr, '0);
	endtask

	// Mostly RAM in the private region, sometimes the I/O window
	task automatic core_random(input int n);
		int pick;
		logic [CORE_AW-1:0] addr;
		repeat (n) begin
			pick = $urandom_range(9);
			if (pick < 7) begin
				addr = $urandom_range(15);
			end else if (pick == 7) begin
				addr = ADDR_LED;
			end else if (pick == 8) begin
				addr = $urandom_range(ADDR_BTN, ADDR_SW);
			end else begin
				addr = $urandom_range(11'h403, 11'h7ff);
			end
			core_access($urandom_range(15), addr, $urandom);
		end
	endtask

	task automatic con_random(input int n);
		repeat (n) begin
			con_access($urandom_range(15), CON_BASE + $urandom_range(15), $urandom);
		end
	endtask

	// Model update and expected data, both taken at the capture edge
	always @(posedge clk) begin
		cycle <= cycle + 1;
		rst_d <= rst;
		if (rst) begin
			core_busy <= 1'b0;
			con_busy <= 1'b0;
			led_model <= '0;
		end else begin
			if (core_rsp_valid) begin
				core_busy <= 1'b0;
			end
			if (con_rsp_valid) begin
				con_busy <= 1'b0;
			end
			if (core_req_valid) begin
				core_busy <= 1'b1;
				core_t0 <= cycle;
				core_mmio <= core_req.addr >= ADDR_BTN;
				core_rd <= core_req.be == '0;
				core_exp <= core_expect(core_req.addr);
				if (core_req.addr < ADDR_BTN) begin
					mem_model[core_req.addr[MEM_AW-1:0]] <= merge_lanes(
						mem_model[core_req.addr[MEM_AW-1:0]], core_req.wdata, core_req.be);
				end else if (core_req.addr == ADDR_LED) begin
					led_model <= merge_lanes(led_model, core_req.wdata, core_req.be);
				end
			end
			if (con_req_valid) begin
				con_busy <= 1'b1;
				con_t0 <= cycle;
				con_rd <= con_req.be == '0;
				con_exp <= mem_model[con_req.addr];
				mem_model[con_req.addr] <= merge_lanes(mem_model[con_req.addr],
					con_req.wdata, con_req.be);
			end
		end
	end

	always @(posedge clk) begin
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("The test timed out after %0d cycles", cycle);
			end_in_failure();
		end
	end

	// Read data against the model
	a_core_data: assert property (@(posedge clk) disable iff (rst)
		core_rsp_valid && core_rd |-> core_rsp.rdata === core_exp)
		else report_mismatch($sformatf("core read %h, expected %h",
			$sampled(core_rsp.rdata), $sampled(core_exp)));

	a_con_data: assert property (@(posedge clk) disable iff (rst)
		con_rsp_valid && con_rd |-> con_rsp.rdata === con_exp)
		else report_mismatch($sformatf("controller read %h, expected %h",
			$sampled(con_rsp.rdata), $sampled(con_exp)));

	// One response per request, 1 cycle for I/O and 2 to 3 for RAM
	a_core_latency: assert property (@(posedge clk) disable iff (rst)
		core_rsp_valid |-> core_busy && (core_mmio ? (cycle - core_t0 == 1)
			: (cycle - core_t0 >= 2 && cycle - core_t0 <= 3)))
		else begin
			$display("Core response came with no request or at the wrong time");
			end_in_failure();
		end

	a_con_latency: assert property (@(posedge clk) disable iff (rst)
		con_rsp_valid |-> con_busy && cycle - con_t0 >= 2 && cycle - con_t0 <= 3)
		else begin
			$display("Controller response came with no request or at the wrong time");
			end_in_failure();
		end

	// LED pins follow the model one cycle after a write, and read zero in reset
	a_led: assert property (@(posedge clk) cycle > 0 |-> led == led_model[LED_W-1:0])
		else report_mismatch($sformatf("led %h, expected %h",
			$sampled(led), $sampled(led_model[LED_W-1:0])));

	a_reset_quiet: assert property (@(posedge clk)
		cycle > 0 && (rst || rst_d) |-> !core_rsp_valid && !con_rsp_valid && led == '0)
		else begin
			$display("Response strobe or LED activity during reset");
			end_in_failure();
		end

	initial begin
		void'($urandom(90018));
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		// Fill both private regions so every later read is defined
		fork
			for (int i = 0; i < 16; i++) begin
				core_access(4'hF, i, $urandom);
			end
			for (int i = 0; i < 16; i++) begin
				con_access(4'hF, CON_BASE + i, $urandom);
			end
		join
		// Full, halfword and byte masks on one word, then read back
		core_access(4'hF, 11'd3, $urandom);
		core_access(4'h3, 11'd3, $urandom);
		core_access(4'hC, 11'd3, $urandom);
		core_access(4'h2, 11'd3, $urandom);
		core_access(4'h0, 11'd3, '0);
		// I/O window
		repeat (8) begin
			core_access($urandom_range(1, 15), ADDR_LED, $urandom);
			core_access(4'h0, ADDR_LED, '0);
			board_read(ADDR_BTN);
			board_read(ADDR_SW);
		end
		core_access(4'hF, 11'h5a5, $urandom);
		core_access(4'h0, 11'h5a5, '0);
		// Both peers strobing on the same edge
		repeat (24) begin
			fork
				core_access($urandom_range(15), $urandom_range(15), $urandom);
				con_access($urandom_range(15), CON_BASE + $urandom_range(15), $urandom);
			join
		end
		// Each peer reads what the other wrote
		con_access(4'hF, SHARED_WORD, $urandom);
		core_access(4'h0, {1'b0, SHARED_WORD}, '0);
		core_access(4'hF, {1'b0, SHARED_WORD + 10'd1}, $urandom);
		con_access(4'h0, SHARED_WORD + 10'd1, '0);
		// Free-running traffic from both sides
		fork
			core_random(330);
			con_random(330);
		join
		repeat (4) @(posedge clk);
		$display("Test completed successfully");
		$finish;
	end

endmodule

//--- sources.f
rtl/dmem_pkg.sv
rtl/dmem_ram.sv
rtl/dmem_req_buffer.sv
rtl/dmem_arbiter.sv
rtl/core_io_port.sv
rtl/datamem_top.sv
testbench/tb_datamem.sv
